/* hw/feature_line_if.sv */
`timescale 1ns/1ps

interface feature_line_if #(
    parameter int FV_SIZE   = gnn_vertex_pkg::FV_SIZE,
    parameter int NODE_ID_W = gnn_vertex_pkg::NODE_ID_W
);
    import gnn_vertex_pkg::*;

    logic                          sos;      // First line of a node packet.
    logic                          eos;      // Last line of a node packet.
    logic [LANES-1:0][FV_SIZE-1:0] fv;
    logic [NODE_ID_W-1:0]          node_id;

    modport rs (
        input sos,
        input eos,
        input fv,
        input node_id
    );

    // Feature bank side.
    modport bank (
        output sos,
        output eos,
        output fv,
        output node_id
    );

endinterface

/* hw/gnn_vertex_pkg.sv */
package gnn_vertex_pkg;

    parameter int FV_SIZE    = 16;  // Bits per feature.
    parameter int MAX_FV_NUM = 16;  // Features per node as a multiple of LANES.
    parameter int NUM_NODES  = 4;   // Nodes per group.
    parameter int NODE_ID_W  = 8;
    parameter int ACC_W      = 40;

    // Features per bank line and per PE window.
    localparam int LANES = 4;

    typedef enum logic [1:0] {
        RS_IDLE,
        RS_RECEIVE,
        RS_WAIT_VERTEX,
        RS_WAIT_BUFFER
    } rs_state_t;

    typedef enum logic {
        PE_IDLE,
        PE_SWEEP
    } pe_state_t;

endpackage

/* hw/gnn_vertex_top.sv */
`timescale 1ns/1ps

module gnn_vertex_top #(
    parameter int FV_SIZE    = gnn_vertex_pkg::FV_SIZE,
    parameter int MAX_FV_NUM = gnn_vertex_pkg::MAX_FV_NUM,
    parameter int NUM_NODES  = gnn_vertex_pkg::NUM_NODES,
    parameter int NODE_ID_W  = gnn_vertex_pkg::NODE_ID_W,
    parameter int ACC_W      = gnn_vertex_pkg::ACC_W
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_sos,
    input  logic                          in_eos,
    input  logic [FV_SIZE-1:0]            in_fv_0,
    input  logic [FV_SIZE-1:0]            in_fv_1,
    input  logic [FV_SIZE-1:0]            in_fv_2,
    input  logic [FV_SIZE-1:0]            in_fv_3,
    input  logic [NODE_ID_W-1:0]          in_node_id,
    input  logic                          weight_we,
    input  logic [$clog2(MAX_FV_NUM)-1:0] weight_addr,
    input  logic [FV_SIZE-1:0]            weight_data,
    output logic                          rs_available,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [NODE_ID_W-1:0]          out_node_id,
    output logic [ACC_W-1:0]              out_value
);
    import gnn_vertex_pkg::*;

    logic                                         fire;
    logic                                         complete;
    logic                                         results_valid;
    logic                                         buf_idle;
    logic [$clog2(MAX_FV_NUM)-1:0]                start_idx;
    logic [NUM_NODES-1:0][LANES-1:0][FV_SIZE-1:0] win_data;
    logic [NUM_NODES-1:0][NODE_ID_W-1:0]          win_node_id;
    logic [NUM_NODES-1:0][ACC_W-1:0]              results;
    logic [NUM_NODES-1:0][NODE_ID_W-1:0]          result_node_id;

    feature_line_if #(.FV_SIZE(FV_SIZE), .NODE_ID_W(NODE_ID_W)) line_if ();

    assign line_if.sos     = in_sos;
    assign line_if.eos     = in_eos;
    assign line_if.fv      = {in_fv_3, in_fv_2, in_fv_1, in_fv_0};  // Lane 0 in the low bits.
    assign line_if.node_id = in_node_id;

    vertex_rs #(
        .FV_SIZE(FV_SIZE), .MAX_FV_NUM(MAX_FV_NUM),
        .NUM_NODES(NUM_NODES), .NODE_ID_W(NODE_ID_W)
    ) u_vertex_rs (
        .clk(clk), .reset(reset), .line(line_if.rs),
        .start_idx(start_idx), .buf_idle(buf_idle), .complete(complete),
        .win_data(win_data), .win_node_id(win_node_id),
        .fire(fire), .rs_available(rs_available), .rs_empty()
    );

    vertex_pe #(
        .FV_SIZE(FV_SIZE), .MAX_FV_NUM(MAX_FV_NUM), .NUM_NODES(NUM_NODES),
        .NODE_ID_W(NODE_ID_W), .ACC_W(ACC_W)
    ) u_vertex_pe (
        .clk(clk), .reset(reset),
        .weight_we(weight_we), .weight_addr(weight_addr), .weight_data(weight_data),
        .fire(fire), .win_data(win_data), .win_node_id(win_node_id),
        .start_idx(start_idx), .complete(complete), .results_valid(results_valid),
        .results(results), .result_node_id(result_node_id)
    );

    vertex_result_buf #(
        .NUM_NODES(NUM_NODES), .NODE_ID_W(NODE_ID_W), .ACC_W(ACC_W)
    ) u_vertex_result_buf (
        .clk(clk), .reset(reset),
        .results_valid(results_valid), .results(results), .result_node_id(result_node_id),
        .out_ready(out_ready), .out_valid(out_valid),
        .out_node_id(out_node_id), .out_value(out_value), .buf_idle(buf_idle)
    );

endmodule

/* hw/vertex_pe.sv */
`timescale 1ns/1ps

module vertex_pe #(
    parameter int FV_SIZE    = gnn_vertex_pkg::FV_SIZE,
    parameter int MAX_FV_NUM = gnn_vertex_pkg::MAX_FV_NUM,
    parameter int NUM_NODES  = gnn_vertex_pkg::NUM_NODES,
    parameter int NODE_ID_W  = gnn_vertex_pkg::NODE_ID_W,
    parameter int ACC_W      = gnn_vertex_pkg::ACC_W
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                weight_we,
    input  logic [$clog2(MAX_FV_NUM)-1:0]       weight_addr,
    input  logic [FV_SIZE-1:0]                  weight_data,
    input  logic                                fire,
    input  logic [NUM_NODES-1:0][gnn_vertex_pkg::LANES-1:0][FV_SIZE-1:0] win_data,
    input  logic [NUM_NODES-1:0][NODE_ID_W-1:0] win_node_id,
    output logic [$clog2(MAX_FV_NUM)-1:0]       start_idx,
    output logic                                complete,
    output logic                                results_valid,
    output logic [NUM_NODES-1:0][ACC_W-1:0]     results,
    output logic [NUM_NODES-1:0][NODE_ID_W-1:0] result_node_id
);
    import gnn_vertex_pkg::*;

    localparam int IDX_W   = $clog2(MAX_FV_NUM);
    localparam int NUM_WIN = MAX_FV_NUM / LANES;
    localparam int CNT_W   = $clog2(NUM_WIN + 2);

    pe_state_t        state;
    logic [CNT_W-1:0] cnt;       // Windows arrive on sweep steps 1 to NUM_WIN.
    logic [IDX_W-1:0] win_base;  // Index of the window now on win_data.
    logic             acc_en;
    logic             last_step;

    logic [MAX_FV_NUM-1:0][FV_SIZE-1:0]              weights;
    logic [NUM_NODES-1:0][LANES-1:0][2*FV_SIZE-1:0] prod;
    logic [NUM_NODES-1:0][ACC_W-1:0]                win_sum;

    assign last_step     = (state == PE_SWEEP) && (cnt == CNT_W'(NUM_WIN + 1));
    assign acc_en        = (state == PE_SWEEP) && (cnt != '0) && (cnt <= CNT_W'(NUM_WIN));
    assign start_idx     = (state == PE_SWEEP && cnt < CNT_W'(NUM_WIN)) ?
                           IDX_W'(cnt * LANES) : '0;
    assign complete      = last_step;
    assign results_valid = last_step;

    always_ff @(posedge clk) begin
        if (weight_we) begin
            weights[weight_addr] <= weight_data;
        end
    end

    always_comb begin
        for (int n = 0; n < NUM_NODES; n++) begin
            win_sum[n] = '0;
            for (int l = 0; l < LANES; l++) begin
                prod[n][l] = win_data[n][l] * weights[win_base + IDX_W'(l)];
                win_sum[n] = win_sum[n] + ACC_W'(prod[n][l]);
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= PE_IDLE;
            cnt      <= '0;
            win_base <= '0;
        end else begin
            win_base <= start_idx;  // RS answers one cycle later.
            case (state)
                PE_IDLE: begin
                    if (fire) begin
                        state <= PE_SWEEP;
                        cnt   <= '0;
                    end
                end
                PE_SWEEP: begin
                    if (last_step) begin
                        state <= PE_IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= PE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == PE_IDLE && fire) begin
            results <= '0;
        end else if (acc_en) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                results[n] <= results[n] + win_sum[n];  // Wraps at ACC_W.
            end
            result_node_id <= win_node_id;
        end
    end

endmodule

/* hw/vertex_result_buf.sv */
`timescale 1ns/1ps

module vertex_result_buf #(
    parameter int NUM_NODES = gnn_vertex_pkg::NUM_NODES,
    parameter int NODE_ID_W = gnn_vertex_pkg::NODE_ID_W,
    parameter int ACC_W     = gnn_vertex_pkg::ACC_W
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                results_valid,
    input  logic [NUM_NODES-1:0][ACC_W-1:0]     results,
    input  logic [NUM_NODES-1:0][NODE_ID_W-1:0] result_node_id,
    input  logic                                out_ready,
    output logic                                out_valid,
    output logic [NODE_ID_W-1:0]                out_node_id,
    output logic [ACC_W-1:0]                    out_value,
    output logic                                buf_idle
);

    localparam int PTR_W = (NUM_NODES > 1) ? $clog2(NUM_NODES) : 1;

    logic [NUM_NODES-1:0][ACC_W-1:0]     vals;
    logic [NUM_NODES-1:0][NODE_ID_W-1:0] ids;
    logic [PTR_W-1:0]                    rd_ptr;
    logic                                busy;  // Results still to be taken.

    assign out_valid   = busy;
    assign buf_idle    = !busy;
    assign out_node_id = ids[rd_ptr];
    assign out_value   = vals[rd_ptr];

    always_ff @(posedge clk) begin
        if (results_valid) begin
            vals <= results;
            ids  <= result_node_id;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy   <= 1'b0;
            rd_ptr <= '0;
        end else if (results_valid) begin
            busy   <= 1'b1;
            rd_ptr <= '0;
        end else if (busy && out_ready) begin
            if (rd_ptr == PTR_W'(NUM_NODES - 1)) begin
                busy   <= 1'b0;  // Last slot taken.
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* hw/vertex_rs.sv */
`timescale 1ns/1ps

module vertex_rs #(
    parameter int FV_SIZE    = gnn_vertex_pkg::FV_SIZE,
    parameter int MAX_FV_NUM = gnn_vertex_pkg::MAX_FV_NUM,
    parameter int NUM_NODES  = gnn_vertex_pkg::NUM_NODES,
    parameter int NODE_ID_W  = gnn_vertex_pkg::NODE_ID_W
) (
    input  logic                                   clk,
    input  logic                                   reset,
    feature_line_if.rs                             line,
    input  logic [$clog2(MAX_FV_NUM)-1:0]          start_idx,
    input  logic                                   buf_idle,
    input  logic                                   complete,
    output logic [NUM_NODES-1:0][gnn_vertex_pkg::LANES-1:0][FV_SIZE-1:0] win_data,
    output logic [NUM_NODES-1:0][NODE_ID_W-1:0]    win_node_id,
    output logic                                   fire,
    output logic                                   rs_available,
    output logic                                   rs_empty
);
    import gnn_vertex_pkg::*;

    localparam int NUM_LINES = MAX_FV_NUM / LANES;
    localparam int LINE_W    = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1;
    localparam int PTR_W     = (NUM_NODES > 1) ? $clog2(NUM_NODES) : 1;

    rs_state_t         state;
    rs_state_t         next_state;
    logic [PTR_W-1:0]  rs_ptr;     // Slot being filled.
    logic [LINE_W-1:0] line_cnt;   // Next line within the slot.
    logic [LINE_W-1:0] win_line;
    logic              last_slot;

    logic [NUM_NODES-1:0][NUM_LINES-1:0][LANES-1:0][FV_SIZE-1:0] fv_mem;
    logic [NUM_NODES-1:0][NODE_ID_W-1:0]                         id_mem;

    assign last_slot    = (rs_ptr == PTR_W'(NUM_NODES - 1));
    assign win_line     = LINE_W'(start_idx / LANES);
    assign rs_available = (state == RS_IDLE);
    assign rs_empty     = (state == RS_IDLE) && (rs_ptr == '0);
    assign fire         = (state == RS_RECEIVE) && line.eos && last_slot;  // Fourth eos.

    always_comb begin
        next_state = state;
        case (state)
            RS_IDLE: begin
                if (line.sos) begin
                    next_state = RS_RECEIVE;
                end
            end
            RS_RECEIVE: begin
                if (line.eos) begin
                    next_state = last_slot ? RS_WAIT_VERTEX : RS_IDLE;
                end
            end
            RS_WAIT_VERTEX: begin
                if (complete) begin
                    next_state = RS_WAIT_BUFFER;
                end
            end
            RS_WAIT_BUFFER: begin
                if (buf_idle) begin
                    next_state = RS_IDLE;  // Group released once results drained.
                end
            end
            default: next_state = RS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= RS_IDLE;
            rs_ptr   <= '0;
            line_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == RS_IDLE && line.sos) begin
                line_cnt <= LINE_W'(1);
            end else if (state == RS_RECEIVE) begin
                if (line.eos) begin
                    line_cnt <= '0;
                    rs_ptr   <= last_slot ? '0 : rs_ptr + 1'b1;
                end else begin
                    line_cnt <= line_cnt + 1'b1;
                end
            end
        end
    end

    // Features a packet leaves out must read as zero.
    always_ff @(posedge clk) begin
        if (state == RS_IDLE && line.sos) begin
            fv_mem[rs_ptr]    <= '0;
            fv_mem[rs_ptr][0] <= line.fv;
            id_mem[rs_ptr]    <= line.node_id;
        end else if (state == RS_RECEIVE) begin
            fv_mem[rs_ptr][line_cnt] <= line.fv;
        end

        if (state == RS_WAIT_VERTEX) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                win_data[n] <= fv_mem[n][win_line];
            end
            win_node_id <= id_mem;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_gnn_vertex -o tb_gnn_vertex \
    && ./obj_dir/tb_gnn_vertex > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed."; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && exit 1 || exit 0

/* sim.f */
hw/gnn_vertex_pkg.sv
hw/feature_line_if.sv
hw/vertex_rs.sv
hw/vertex_pe.sv
hw/vertex_result_buf.sv
hw/gnn_vertex_top.sv
verification/tb_clock_gen.sv
verification/tb_gnn_vertex.sv

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b0;  // Active low.
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
    end

endmodule

/* verification/tb_gnn_vertex.sv */
`timescale 1ns/1ps

module tb_gnn_vertex;
    import gnn_vertex_pkg::*;

    localparam int IDX_W     = $clog2(MAX_FV_NUM);
    localparam int NUM_LINES = MAX_FV_NUM / LANES;
    localparam int TIMEOUT   = 200;  // Cycles per wait.

    typedef logic [MAX_FV_NUM-1:0][FV_SIZE-1:0] fv_vec_t;

    logic                 clk;
    logic                 reset;
    logic                 in_sos;
    logic                 in_eos;
    logic [FV_SIZE-1:0]   in_fv_0;
    logic [FV_SIZE-1:0]   in_fv_1;
    logic [FV_SIZE-1:0]   in_fv_2;
    logic [FV_SIZE-1:0]   in_fv_3;
    logic [NODE_ID_W-1:0] in_node_id;
    logic                 weight_we;
    logic [IDX_W-1:0]     weight_addr;
    logic [FV_SIZE-1:0]   weight_data;
    logic                 rs_available;
    logic                 out_valid;
    logic                 out_ready;
    logic [NODE_ID_W-1:0] out_node_id;
    logic [ACC_W-1:0]     out_value;
    logic                 bp_mode;      // Random back-pressure on out_ready.
    fv_vec_t              weights;
    int                   id_errors;
    int                   value_errors;
    int                   other_errors;
    logic [NODE_ID_W-1:0] exp_ids[$];
    logic [ACC_W-1:0]     exp_vals[$];

    tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

    gnn_vertex_top #(
        .FV_SIZE(FV_SIZE), .MAX_FV_NUM(MAX_FV_NUM), .NUM_NODES(NUM_NODES),
        .NODE_ID_W(NODE_ID_W), .ACC_W(ACC_W)
    ) u_gnn_vertex_top (
        .clk(clk), .reset(reset), .in_sos(in_sos), .in_eos(in_eos),
        .in_fv_0(in_fv_0), .in_fv_1(in_fv_1), .in_fv_2(in_fv_2), .in_fv_3(in_fv_3),
        .in_node_id(in_node_id), .weight_we(weight_we), .weight_addr(weight_addr),
        .weight_data(weight_data), .rs_available(rs_available), .out_valid(out_valid),
        .out_ready(out_ready), .out_node_id(out_node_id), .out_value(out_value)
    );

    // Dot product of one node's features and the weights modulo 2**ACC_W.
    function automatic logic [ACC_W-1:0] ref_vertex(input fv_vec_t feat, input fv_vec_t w);
        logic [ACC_W-1:0]     sum;
        logic [2*FV_SIZE-1:0] prod;
        sum = '0;
        for (int i = 0; i < MAX_FV_NUM; i++) begin
            prod = feat[i] * w[i];
            sum  = sum + ACC_W'(prod);
        end
        return sum;
    endfunction

    task automatic check_node_id(input logic [NODE_ID_W-1:0] got,
                                 input logic [NODE_ID_W-1:0] exp);
        if (got !== exp) begin
            id_errors++;
            $display("mismatch out_node_id: got 0x%h, expected 0x%h", got, exp);
        end
    endtask

    task automatic check_value(input logic [ACC_W-1:0] got, input logic [ACC_W-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("mismatch out_value: got 0x%h, expected 0x%h", got, exp);
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset !== 1'b1 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b1) begin
            other_errors++;
            $display("Reset was never released.");
        end
    endtask

    task automatic wait_available();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!rs_available && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rs_available) begin
            other_errors++;
            $display("rs_available did not rise within %0d cycles.", TIMEOUT);
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_ids.size() != 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_ids.size() != 0) begin
            other_errors++;
            $display("%0d results never came out on out_valid.", exp_ids.size());
        end
    endtask

    task automatic load_weights();
        wait_available();
        for (int i = 0; i < MAX_FV_NUM; i++) begin
            weights[i] = FV_SIZE'($urandom);
            @(posedge clk);
            weight_we   <= 1'b1;
            weight_addr <= IDX_W'(i);
            weight_data <= weights[i];
        end
        @(posedge clk);
        weight_we <= 1'b0;
    endtask

    task automatic send_packet(input logic [NODE_ID_W-1:0] id, input fv_vec_t feat,
                               input int nlines);
        wait_available();
        for (int k = 0; k < nlines; k++) begin
            @(posedge clk);
            in_sos     <= (k == 0);
            in_eos     <= (k == nlines - 1);
            in_fv_0    <= feat[4*k];
            in_fv_1    <= feat[4*k+1];
            in_fv_2    <= feat[4*k+2];
            in_fv_3    <= feat[4*k+3];
            in_node_id <= id;
        end
        @(posedge clk);  // Edge that takes the eos line.
        in_sos <= 1'b0;
        in_eos <= 1'b0;
    endtask

    // Four packets of nlines lines each; expected results queued in slot order.
    task automatic run_group(input int nlines, input bit new_weights);
        fv_vec_t              feat;
        logic [NODE_ID_W-1:0] id;
        if (new_weights) begin
            load_weights();
        end
        for (int n = 0; n < NUM_NODES; n++) begin
            feat = '0;
            for (int i = 0; i < nlines * LANES; i++) begin
                feat[i] = FV_SIZE'($urandom);
            end
            id = NODE_ID_W'($urandom);
            exp_ids.push_back(id);
            exp_vals.push_back(ref_vertex(feat, weights));
            send_packet(id, feat, nlines);
        end
    endtask

    always @(posedge clk) begin
        out_ready <= bp_mode ? 1'($urandom_range(0, 1)) : 1'b1;
    end

    // A transfer seen at a falling edge completes on the next rising edge.
    always @(negedge clk) begin
        if (reset === 1'b1 && out_valid) begin
            if (rs_available) begin
                other_errors++;
                $display("rs_available is high while results are still pending.");
            end
            if (out_ready) begin
                if (exp_ids.size() == 0) begin
                    other_errors++;
                    $display("Result 0x%h came out with none expected.", out_value);
                end else begin
                    check_node_id(out_node_id, exp_ids.pop_front());
                    check_value(out_value, exp_vals.pop_front());
                end
            end
        end
    end

    initial begin
        void'($urandom(4420));
        id_errors    = 0;
        value_errors = 0;
        other_errors = 0;
        bp_mode      <= 1'b0;
        in_sos       <= 1'b0;
        in_eos       <= 1'b0;
        in_fv_0      <= '0;
        in_fv_1      <= '0;
        in_fv_2      <= '0;
        in_fv_3      <= '0;
        in_node_id   <= '0;
        weight_we    <= 1'b0;
        weight_addr  <= '0;
        weight_data  <= '0;
        out_ready    <= 1'b1;

        wait_reset_release();
        @(negedge clk);
        if (!rs_available || out_valid) begin
            other_errors++;
            $display("After reset rs_available is not high or out_valid is not low.");
        end

        run_group(NUM_LINES, 1'b1);
        run_group(2, 1'b0);          // Short packets on the weights already loaded.
        wait_drained();
        bp_mode <= 1'b1;
        run_group(NUM_LINES, 1'b1);
        wait_drained();
        wait_available();
        bp_mode <= 1'b0;
        run_group(NUM_LINES, 1'b1);  // Sent as soon as the station frees.
        run_group(3, 1'b1);
        wait_drained();
        wait_available();

        $display("Errors: node id %0d, value %0d, other %0d",
                 id_errors, value_errors, other_errors);
        if (id_errors + value_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
